/* common/da_cfg.svh */
`ifndef DA_CFG_SVH
`define DA_CFG_SVH

// selection word and table slicing.
`define DA_SIZE      12
`define DA_LUT_SIZE  4

// coefficient format, Q15.16 plus sign.
`define DA_N_INT     15
`define DA_N_FRAC    16

// cycles through one fp_add.
`define FP_ADD_LAT   2

// coefficients scaled by 2**16, all multiples of 0.25.
`define DA_FACT_0    212992
`define DA_FACT_1    1146880
`define DA_FACT_2    6602752
`define DA_FACT_3    786432
`define DA_FACT_4    16384
`define DA_FACT_5    4161536
`define DA_FACT_6    16760832
// same as coefficient 1.
`define DA_FACT_7    1146880
`define DA_FACT_8    9846784
`define DA_FACT_9    65536
`define DA_FACT_10   2932736
// sum of all the others, so a lone bit 11 cancels to zero.
`define DA_FACT_11   43679744

`endif

/* common/fp_pkg.sv */
package fp_pkg;

    localparam int EXP_W = 8;
    localparam int MANT_W = 23;
    localparam int EXP_BIAS = 127;

    // width of the fixed-point argument to the converter.
    localparam int FIX_W = 64;

    // single precision layout, hidden leading one.
    typedef struct packed {
        logic               sign;
        logic [EXP_W-1:0]   exp;
        logic [MANT_W-1:0]  mant;
    } float_t;

    // signed fixed point to float, mantissa truncated.
    function automatic float_t fix_to_float(
        logic signed [FIX_W-1:0] val,
        int frac_bits
    );
        float_t f;
        logic [FIX_W-1:0] mag;
        int msb;

        f = '0;
        msb = 0;
        if (val < 0) begin
            mag = -val;
        end else begin
            mag = val;
        end

        // position of the leading one.
        for (int i = 0; i < FIX_W; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end

        if (mag != '0) begin
            f.sign = (val < 0);
            f.exp = EXP_W'(msb - frac_bits + EXP_BIAS);
            if (msb >= MANT_W) begin
                f.mant = MANT_W'(mag >> (msb - MANT_W));
            end else begin
                f.mant = MANT_W'(mag << (MANT_W - msb));
            end
        end

        return f;
    endfunction

endpackage

/* common/da_pkg.sv */
`include "da_cfg.svh"

package da_pkg;

    // signed coefficient, integer and fraction bits plus sign.
    typedef logic signed [`DA_N_INT+`DA_N_FRAC:0] fix_t;

    // one bit per coefficient, 1 adds and 0 subtracts.
    typedef logic [`DA_SIZE-1:0] sel_t;

    // the full coefficient vector, index 0 first.
    typedef fix_t fact_arr_t [`DA_SIZE];

endpackage

/* verilog/da_lut.sv */
`include "da_cfg.svh"

module da_lut #(
    parameter int k = `DA_LUT_SIZE,
    // entries 0 to k-1 hold this slice's coefficients.
    parameter da_pkg::fact_arr_t fact = '{default: '0}
) (
    input  logic [k-1:0]   sel,
    output fp_pkg::float_t result
);

    fp_pkg::float_t lut_mem [2**k];

    // signed sum of the slice for one address.
    function automatic da_pkg::fix_t slice_sum(logic [k-1:0] addr);
        da_pkg::fix_t acc;

        acc = '0;
        for (int j = 0; j < k; j++) begin
            if (addr[j]) begin
                acc = acc + fact[j];
            end else begin
                acc = acc - fact[j];
            end
        end
        return acc;
    endfunction

    for (genvar i = 0; i < 2**k; i++) begin : g_entry
        localparam fp_pkg::float_t ENTRY =
            fp_pkg::fix_to_float(slice_sum(k'(i)), `DA_N_FRAC);

        assign lut_mem[i] = ENTRY;
    end

    assign result = lut_mem[sel];

endmodule

/* fp_add/fp_add.sv */
module fp_add (
    input  logic           clk,
    input  fp_pkg::float_t a,
    input  fp_pkg::float_t b,
    output fp_pkg::float_t sum
);

    localparam int EW = fp_pkg::EXP_W;
    localparam int MW = fp_pkg::MANT_W;
    localparam int LZW = $clog2(MW + 1);

    fp_pkg::float_t op_big;
    fp_pkg::float_t op_small;
    logic [EW-1:0]  exp_diff;
    logic [MW:0]    big_sig;
    logic [MW:0]    small_sig;
    logic [MW:0]    small_aligned;

    logic           s1_sign;
    logic           s1_sub;
    logic [EW-1:0]  s1_exp;
    logic [MW:0]    s1_big;
    logic [MW:0]    s1_small;

    logic [MW+1:0]  raw;
    logic [LZW-1:0] lz;
    logic [MW:0]    norm_sig;
    fp_pkg::float_t sum_d;

    function automatic logic [LZW-1:0] lzc(logic [MW:0] v);
        logic [LZW-1:0] n;

        n = '0;
        for (int i = 0; i <= MW; i++) begin
            if (v[i]) begin
                n = LZW'(MW - i);
            end
        end
        return n;
    endfunction

    // stage one: order by magnitude, align the smaller one.
    always_comb begin
        if ({a.exp, a.mant} >= {b.exp, b.mant}) begin
            op_big = a;
            op_small = b;
        end else begin
            op_big = b;
            op_small = a;
        end
        exp_diff = op_big.exp - op_small.exp;
        big_sig = {op_big.exp != '0, op_big.mant};
        small_sig = {op_small.exp != '0, op_small.mant};
        if (exp_diff > EW'(MW)) begin
            small_aligned = '0;
        end else begin
            small_aligned = small_sig >> exp_diff;
        end
    end

    always_ff @(posedge clk) begin
        s1_sign <= op_big.sign;
        s1_sub <= op_big.sign ^ op_small.sign;
        s1_exp <= op_big.exp;
        s1_big <= big_sig;
        s1_small <= small_aligned;
    end

    // stage two: add, renormalize, truncate.
    always_comb begin
        if (s1_sub) begin
            raw = {1'b0, s1_big} - {1'b0, s1_small};
        end else begin
            raw = {1'b0, s1_big} + {1'b0, s1_small};
        end
        lz = lzc(raw[MW:0]);
        norm_sig = raw[MW:0] << lz;
        sum_d = '0;
        if (raw[MW+1]) begin
            sum_d.sign = s1_sign;
            sum_d.exp = s1_exp + 1'b1;
            sum_d.mant = raw[MW:1];
        end else if (raw[MW:0] != '0 && s1_exp > EW'(lz)) begin
            sum_d.sign = s1_sign;
            sum_d.exp = s1_exp - EW'(lz);
            sum_d.mant = norm_sig[MW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        sum <= sum_d;
    end

    // no infinities, so overflow has no encoding.
    assert property (@(posedge clk) disable iff ($isunknown(sum))
        (sum != '0) |-> (sum.exp != '1));

endmodule

/* fp_add/fp_add_tree.sv */
module fp_add_tree #(
    parameter int n = 3
) (
    input  logic           clk,
    input  fp_pkg::float_t in [n],
    output fp_pkg::float_t out
);

    localparam int DEPTH = $clog2(n);
    localparam int LEAVES = 2**DEPTH;

    // heap order: node 0 is the root, leaves sit at the end.
    fp_pkg::float_t node [2*LEAVES-1];

    for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
        if (i < n) begin : g_used
            assign node[LEAVES-1+i] = in[i];
        end else begin : g_pad
            // positive zero leaves the other operand unchanged.
            assign node[LEAVES-1+i] = '0;
        end
    end

    for (genvar j = 0; j < LEAVES - 1; j++) begin : g_node
        fp_add u_add (
            .clk (clk),
            .a   (node[2*j+1]),
            .b   (node[2*j+2]),
            .sum (node[j])
        );
    end

    assign out = node[0];

endmodule

/* verilog/da_unit.sv */
`include "da_cfg.svh"

module da_unit #(
    parameter da_pkg::fact_arr_t fact = '{default: '0}
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  da_pkg::sel_t   sel,
    output logic           out_valid,
    output fp_pkg::float_t result
);

    localparam int N_LUTS = (`DA_SIZE + `DA_LUT_SIZE - 1) / `DA_LUT_SIZE;
    localparam int LAST_K = `DA_SIZE - (N_LUTS - 1) * `DA_LUT_SIZE;
    // table register plus the adder tree.
    localparam int LAT = 1 + `FP_ADD_LAT * $clog2(N_LUTS);

    fp_pkg::float_t lut_d [N_LUTS];
    fp_pkg::float_t lut_q [N_LUTS];
    logic [LAT-1:0] valid_sr;

    // coefficients from off onward moved down to index 0.
    function automatic da_pkg::fact_arr_t slice_of(int off);
        da_pkg::fact_arr_t s;

        for (int j = 0; j < `DA_SIZE; j++) begin
            if (off + j < `DA_SIZE) begin
                s[j] = fact[off + j];
            end else begin
                s[j] = '0;
            end
        end
        return s;
    endfunction

    for (genvar i = 0; i < N_LUTS; i++) begin : g_lut
        localparam int OFF = i * `DA_LUT_SIZE;
        localparam int K = (i == N_LUTS - 1) ? LAST_K : `DA_LUT_SIZE;

        da_lut #(.k(K), .fact(slice_of(OFF))) u_lut (
            .sel    (sel[OFF +: K]),
            .result (lut_d[i])
        );
    end

    always_ff @(posedge clk) begin
        lut_q <= lut_d;
    end

    fp_add_tree #(.n(N_LUTS)) u_tree (
        .clk (clk),
        .in  (lut_q),
        .out (result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LAT-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[LAT-1];

    assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid));

endmodule

/* verilog/da_top.sv */
`include "da_cfg.svh"

module da_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  da_pkg::sel_t   sel,
    output logic           out_valid,
    output fp_pkg::float_t result
);

    localparam da_pkg::fact_arr_t FACT = '{
        `DA_FACT_0, `DA_FACT_1, `DA_FACT_2, `DA_FACT_3,
        `DA_FACT_4, `DA_FACT_5, `DA_FACT_6, `DA_FACT_7,
        `DA_FACT_8, `DA_FACT_9, `DA_FACT_10, `DA_FACT_11
    };

    da_unit #(.fact(FACT)) u_unit (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .sel       (sel),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

/* testbench/tb_da_top.sv */
`include "da_cfg.svh"

module tb_da_top;

    localparam int LAT = 5;

    localparam longint FACT_TB [`DA_SIZE] = '{
        `DA_FACT_0, `DA_FACT_1, `DA_FACT_2, `DA_FACT_3,
        `DA_FACT_4, `DA_FACT_5, `DA_FACT_6, `DA_FACT_7,
        `DA_FACT_8, `DA_FACT_9, `DA_FACT_10, `DA_FACT_11
    };

    logic           clk;
    logic           rst;
    logic           in_valid;
    da_pkg::sel_t   sel;
    logic           out_valid;
    fp_pkg::float_t result;

    int             cyc = 0;
    int             n_checks = 0;
    int             n_errors = 0;
    logic [15:0]    lfsr = 16'd47;
    fp_pkg::float_t exp_val [$];
    int             exp_due [$];

    da_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .sel       (sel),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_float(string name, fp_pkg::float_t got, fp_pkg::float_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    // x^16 + x^15 + x^13 + x^4 + 1.
    function automatic logic lfsr_bit();
        logic fb;

        fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic da_pkg::sel_t rand_sel();
        da_pkg::sel_t s;

        for (int i = 0; i < `DA_SIZE; i++) begin
            s[i] = lfsr_bit();
        end
        return s;
    endfunction

    // bit set adds the coefficient, bit clear subtracts it.
    function automatic longint model_sum(da_pkg::sel_t s);
        longint acc;

        acc = 0;
        for (int j = 0; j < `DA_SIZE; j++) begin
            acc = s[j] ? acc + FACT_TB[j] : acc - FACT_TB[j];
        end
        return acc;
    endfunction

    // float of a fixed-point value, normalized to bit 62 then truncated.
    function automatic fp_pkg::float_t model_float(longint v);
        fp_pkg::float_t f;
        logic [63:0] mag;
        int sh;

        f = '0;
        sh = 0;
        mag = (v < 0) ? 64'(-v) : 64'(v);
        if (mag != '0) begin
            while (!mag[62]) begin
                mag = mag << 1;
                sh++;
            end
            f.sign = (v < 0);
            f.exp = 8'(62 - sh - `DA_N_FRAC + fp_pkg::EXP_BIAS);
            f.mant = mag[61:39];
        end
        return f;
    endfunction

    // output monitor, sampled mid-cycle.
    always @(negedge clk) begin : monitor
        logic exp_v;

        if (cyc >= 1) begin
            exp_v = (exp_due.size() > 0) && (exp_due[0] == cyc);
            check_bit("out_valid", out_valid, exp_v);
            if (exp_v) begin
                if (out_valid) begin
                    check_float("result", result, exp_val[0]);
                end
                void'(exp_due.pop_front());
                void'(exp_val.pop_front());
            end
        end
    end

    task automatic drive_sample(da_pkg::sel_t s);
        in_valid = 1'b1;
        sel = s;
        exp_val.push_back(model_float(model_sum(s)));
        exp_due.push_back(cyc + LAT);
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        in_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int n;

        n = 0;
        in_valid = 1'b0;
        while (exp_due.size() > 0 && n < 4 * LAT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_due.size() > 0) begin
            $display("timeout: %0d results never arrived", exp_due.size());
            n_errors++;
            exp_due.delete();
            exp_val.delete();
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            if (i == 3) begin
                rst = 1'b0;
            end
            check_bit("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic test_extremes();
        drive_sample('1);
        wait_drain();
        drive_sample('0);
        wait_drain();
    endtask

    // one-hot and one-cold words, bit 11 alone cancels to zero.
    task automatic test_walking();
        for (int j = 0; j < `DA_SIZE; j++) begin
            drive_sample(da_pkg::sel_t'(1) << j);
        end
        for (int j = 0; j < `DA_SIZE; j++) begin
            drive_sample(~(da_pkg::sel_t'(1) << j));
        end
        wait_drain();
    endtask

    task automatic test_burst();
        for (int i = 0; i < 64; i++) begin
            drive_sample(rand_sel());
        end
        wait_drain();
    endtask

    task automatic test_gaps();
        for (int i = 0; i < 64; i++) begin
            if (lfsr_bit()) begin
                drive_sample(rand_sel());
            end else begin
                idle_cycle();
            end
        end
        wait_drain();
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        sel = '0;
        test_reset_idle();
        test_extremes();
        test_walking();
        test_burst();
        test_gaps();
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/fp_pkg.sv
common/da_pkg.sv
verilog/da_lut.sv
fp_add/fp_add.sv
fp_add/fp_add_tree.sv
verilog/da_unit.sv
verilog/da_top.sv
testbench/tb_da_top.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_da_top
FLIST    := list.f
OBJDIR   := obj_dir

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJDIR)
